// File: rtl/i2s_pkg.sv
package i2s_pkg;

    // ----------------------------------------
    // Frame layout
    // ----------------------------------------
    localparam int FRAME_BITS      = 64;
    localparam int SAMPLE_BITS     = 24;
    localparam int LEFT_MSB        = 62;    // One bit after the word-select edge.
    localparam int RIGHT_MSB       = 30;
    localparam int BIT_COUNT_BITS  = 7;

    // ----------------------------------------
    // Clock division from audio_clk
    // ----------------------------------------
    localparam int I2S_DIV_BITS    = 5;     // 98.304 MHz / 32 = 3.072 MHz.
    localparam int LRCL_BITS       = 11;    // 2048 cycles per frame, 48 kHz.
    localparam int LRCL_HIGH_START = 32;
    localparam int LRCL_HIGH_END   = 1057;

    localparam int FIFO_DEPTH      = 8;
    localparam int FIFO_PTR_BITS   = $clog2(FIFO_DEPTH);

    typedef logic [FRAME_BITS-1:0]         frame_t;
    typedef logic signed [SAMPLE_BITS-1:0] sample_t;

    typedef struct packed {
        frame_t data;
        logic   valid;
    } frame_msg_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    typedef struct packed {
        stereo_t data;
        logic    valid;
    } stereo_msg_t;

    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fill_t;
    typedef logic [3:0]                      axil_addr_t;

    localparam axil_addr_t ADDR_CTRL   = 4'h0;
    localparam axil_addr_t ADDR_STATUS = 4'h4;
    localparam axil_addr_t ADDR_LEFT   = 4'h8;
    localparam axil_addr_t ADDR_RIGHT  = 4'hC;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: rtl/i2s_clock_gen.sv
`timescale 1ns/100ps

module i2s_clock_gen (
    input  logic audio_clk,
    input  logic rst_in,
    output logic i2s_clk,
    output logic lrcl_clk,
    output logic bit_strobe,
    output logic frame_start
);
    import i2s_pkg::*;

    logic [I2S_DIV_BITS-1:0] bit_cnt;
    logic [LRCL_BITS-1:0]    frame_cnt;

    // ----------------------------------------
    // Free-running counters
    // ----------------------------------------
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            bit_cnt   <= '0;
            frame_cnt <= '0;
        end else begin
            bit_cnt   <= bit_cnt + 1'b1;
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    assign i2s_clk  = bit_cnt[I2S_DIV_BITS-1];    // High for counts 16..31.
    assign lrcl_clk = (frame_cnt >= LRCL_BITS'(LRCL_HIGH_START)) &&
                      (frame_cnt < LRCL_BITS'(LRCL_HIGH_END));

    // Both strobes are decoded one count early and registered, so each lands
    // in the first cycle after its clock has gone low.
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            bit_strobe  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            bit_strobe  <= (bit_cnt == '1);                               // Count 0 next.
            frame_start <= (frame_cnt == LRCL_BITS'(LRCL_HIGH_END - 1));  // Count 1057 next.
        end
    end

endmodule

// File: rtl/i2s_deserializer.sv
`timescale 1ns/100ps

module i2s_deserializer (
    input  logic                audio_clk,
    input  logic                rst_in,
    input  logic                mic_data,
    input  logic                capture_enable,
    input  logic                bit_strobe,
    input  logic                frame_start,
    output i2s_pkg::frame_msg_t frame
);
    import i2s_pkg::*;

    typedef enum logic {
        IDLE,
        ACCUMULATING
    } state_t;

    state_t                    state;
    frame_t                    shift_q;
    logic                      valid_q;
    logic [BIT_COUNT_BITS-1:0] bit_count;
    logic                      last_bit;

    assign last_bit = bit_strobe && (bit_count == BIT_COUNT_BITS'(FRAME_BITS - 1));

    // ----------------------------------------
    // Frame FSM
    // ----------------------------------------
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state     <= IDLE;
            bit_count <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state)
                IDLE: begin
                    bit_count <= '0;
                    if (frame_start && capture_enable) begin
                        state <= ACCUMULATING;
                    end
                end
                ACCUMULATING: begin
                    if (bit_strobe) begin
                        bit_count <= bit_count + 1'b1;
                    end
                    if (last_bit) begin
                        valid_q <= 1'b1;    // Back in IDLE in time for the next frame_start.
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // The shift register holds the finished frame until the next frame's first bit.
    always_ff @(posedge audio_clk) begin
        if (state == ACCUMULATING && bit_strobe) begin
            shift_q <= {shift_q[FRAME_BITS-2:0], mic_data};    // MSB first.
        end
    end

    assign frame = '{data: shift_q, valid: valid_q};

endmodule

// File: rtl/channel_splitter.sv
`timescale 1ns/100ps

module channel_splitter (
    input  logic                 audio_clk,
    input  logic                 rst_in,
    input  i2s_pkg::frame_msg_t  frame,
    output i2s_pkg::stereo_msg_t stereo
);
    import i2s_pkg::*;

    stereo_t pair_q;
    logic    valid_q;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= frame.valid;
        end
    end

    // ----------------------------------------
    // Field extraction
    // ----------------------------------------
    // Each word starts one bit after its word-select edge, so the fields sit
    // just below bit 63 and bit 31 and the low 7 bits of each half are padding.
    always_ff @(posedge audio_clk) begin
        if (frame.valid) begin
            pair_q.left  <= frame.data[LEFT_MSB -: SAMPLE_BITS];    // Bits 62..39.
            pair_q.right <= frame.data[RIGHT_MSB -: SAMPLE_BITS];   // Bits 30..7.
        end
    end

    assign stereo = '{data: pair_q, valid: valid_q};

endmodule

// File: rtl/sample_fifo.sv
`timescale 1ns/100ps

module sample_fifo (
    input  logic                 audio_clk,
    input  logic                 rst_in,
    input  i2s_pkg::stereo_msg_t stereo,
    input  logic                 pop,
    input  logic                 overflow_clear,
    output i2s_pkg::stereo_t     head,
    output logic                 empty,
    output i2s_pkg::fill_t       fill,
    output logic                 overflow
);
    import i2s_pkg::*;

    stereo_t                  mem [FIFO_DEPTH];
    logic [FIFO_PTR_BITS-1:0] wr_ptr;
    logic [FIFO_PTR_BITS-1:0] rd_ptr;
    logic                     full;
    logic                     do_push;
    logic                     do_pop;

    assign empty   = (fill == '0);
    assign full    = (fill == fill_t'(FIFO_DEPTH));
    assign do_push = stereo.valid && !full;    // A pair arriving at full is lost.
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge audio_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= stereo.data;
        end
    end

    // ----------------------------------------
    // Pointers, fill and overflow
    // ----------------------------------------
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill     <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at the depth.
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // a new drop outranks a clear in the same cycle
            if (stereo.valid && full) begin
                overflow <= 1'b1;
            end else if (overflow_clear) begin
                overflow <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/axil_sample_regs.sv
`timescale 1ns/100ps

module axil_sample_regs (
    input  logic                audio_clk,
    input  logic                rst_in,
    input  i2s_pkg::axil_addr_t awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  i2s_pkg::axil_addr_t araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    input  i2s_pkg::stereo_t    head,
    input  logic                empty,
    input  i2s_pkg::fill_t      fill,
    input  logic                overflow,
    output logic                pop,
    output logic                overflow_clear,
    output logic                capture_enable
);
    import i2s_pkg::*;

    logic        wr_fire;
    logic        rd_fire;
    logic        ctrl_wr;
    logic        pop_pending;
    logic [31:0] left_word;
    logic [31:0] right_word;
    logic [31:0] rd_word;

    // Only bits 3:2 select a register, so every address maps to one of the four.
    function automatic axil_addr_t reg_sel(axil_addr_t addr);
        return {addr[3:2], 2'b00};
    endfunction

    // ----------------------------------------
    // Write channel
    // ----------------------------------------
    assign wr_fire        = awvalid && wvalid && !bvalid;    // AW and W taken together.
    assign awready        = wr_fire;
    assign wready         = wr_fire;
    assign ctrl_wr        = wr_fire && (reg_sel(awaddr) == ADDR_CTRL) && wstrb[0];
    assign overflow_clear = ctrl_wr && wdata[1];

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            bvalid         <= 1'b0;
            capture_enable <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (ctrl_wr) begin
                capture_enable <= wdata[0];
            end
        end
    end

    always_ff @(posedge audio_clk) begin
        if (wr_fire) begin
            bresp <= (wstrb == '0) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // ----------------------------------------
    // Read channel
    // ----------------------------------------
    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;
    assign rresp   = RESP_OKAY;
    assign pop     = rvalid && rready && pop_pending;    // Completed read of RIGHT.

    assign left_word  = empty ? '0 :
                        {{(32 - SAMPLE_BITS){head.left[SAMPLE_BITS-1]}}, head.left};
    assign right_word = empty ? '0 :
                        {{(32 - SAMPLE_BITS){head.right[SAMPLE_BITS-1]}}, head.right};

    always_comb begin
        case (reg_sel(araddr))
            ADDR_CTRL:   rd_word = {31'b0, capture_enable};
            ADDR_STATUS: rd_word = {24'b0, fill, 2'b00, overflow, !empty};
            ADDR_LEFT:   rd_word = left_word;
            ADDR_RIGHT:  rd_word = right_word;
            default:     rd_word = '0;
        endcase
    end

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            rvalid      <= 1'b0;
            pop_pending <= 1'b0;
        end else begin
            if (rd_fire) begin
                rvalid      <= 1'b1;
                pop_pending <= (reg_sel(araddr) == ADDR_RIGHT) && !empty;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // The read word is captured at AR time and held through any back-pressure.
    always_ff @(posedge audio_clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
    end

endmodule

// File: rtl/i2s_mic_capture.sv
`timescale 1ns/100ps

module i2s_mic_capture (
    input  logic                audio_clk,
    input  logic                rst_in,
    input  logic                mic_data,
    output logic                i2s_clk,
    output logic                lrcl_clk,
    input  i2s_pkg::axil_addr_t awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  i2s_pkg::axil_addr_t araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready
);
    import i2s_pkg::*;

    logic        bit_strobe;
    logic        frame_start;
    logic        capture_enable;
    frame_msg_t  frame_msg;
    stereo_msg_t stereo_msg;
    stereo_t     fifo_head;
    logic        fifo_empty;
    fill_t       fifo_fill;
    logic        fifo_overflow;
    logic        fifo_pop;
    logic        overflow_clear;

    // ----------------------------------------
    // Capture pipeline
    // ----------------------------------------
    i2s_clock_gen i2s_clock_gen_i (
        .audio_clk   (audio_clk),
        .rst_in      (rst_in),
        .i2s_clk     (i2s_clk),
        .lrcl_clk    (lrcl_clk),
        .bit_strobe  (bit_strobe),
        .frame_start (frame_start)
    );

    i2s_deserializer i2s_deserializer_i (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .mic_data       (mic_data),
        .capture_enable (capture_enable),
        .bit_strobe     (bit_strobe),
        .frame_start    (frame_start),
        .frame          (frame_msg)
    );

    channel_splitter channel_splitter_i (
        .audio_clk (audio_clk),
        .rst_in    (rst_in),
        .frame     (frame_msg),
        .stereo    (stereo_msg)
    );

    sample_fifo sample_fifo_i (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .stereo         (stereo_msg),
        .pop            (fifo_pop),
        .overflow_clear (overflow_clear),
        .head           (fifo_head),
        .empty          (fifo_empty),
        .fill           (fifo_fill),
        .overflow       (fifo_overflow)
    );

    // ----------------------------------------
    // Host register interface
    // ----------------------------------------
    axil_sample_regs axil_sample_regs_i (
        .audio_clk      (audio_clk),
        .rst_in         (rst_in),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wvalid         (wvalid),
        .wready         (wready),
        .bresp          (bresp),
        .bvalid         (bvalid),
        .bready         (bready),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rvalid         (rvalid),
        .rready         (rready),
        .head           (fifo_head),
        .empty          (fifo_empty),
        .fill           (fifo_fill),
        .overflow       (fifo_overflow),
        .pop            (fifo_pop),
        .overflow_clear (overflow_clear),
        .capture_enable (capture_enable)
    );

endmodule

// File: tests/i2s_mic_capture_props.sv
`timescale 1ns/100ps

module i2s_mic_capture_props (
    input logic        audio_clk,
    input logic        rst_in,
    input logic        i2s_clk,
    input logic        lrcl_clk,
    input logic        frame_valid,
    input logic        bvalid,
    input logic        bready,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata
);

    // ----------------------------------------
    // AXI response channels
    // ----------------------------------------
    rvalid_held: assert property (@(posedge audio_clk) disable iff (rst_in)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    bvalid_held: assert property (@(posedge audio_clk) disable iff (rst_in)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rdata_stable: assert property (@(posedge audio_clk) disable iff (rst_in)
        rvalid && !rready |=> rdata == $past(rdata))
        else $error("rdata changed while the read response was stalled");

    // ----------------------------------------
    // Capture path
    // ----------------------------------------
    frame_single: assert property (@(posedge audio_clk) disable iff (rst_in)
        frame_valid |=> !frame_valid)
        else $error("frame valid high in two consecutive cycles");

    lrcl_on_low: assert property (@(posedge audio_clk) disable iff (rst_in)
        lrcl_clk != $past(lrcl_clk) |-> !i2s_clk)
        else $error("lrcl_clk changed while i2s_clk was high");

endmodule

bind i2s_mic_capture i2s_mic_capture_props i2s_mic_capture_props_i (
    .audio_clk   (audio_clk),
    .rst_in      (rst_in),
    .i2s_clk     (i2s_clk),
    .lrcl_clk    (lrcl_clk),
    .frame_valid (frame_msg.valid),
    .bvalid      (bvalid),
    .bready      (bready),
    .rvalid      (rvalid),
    .rready      (rready),
    .rdata       (rdata)
);

// File: tests/tb_i2s_mic_capture.sv
`timescale 1ns/100ps

module tb_i2s_mic_capture;
    import i2s_pkg::*;

    localparam int TIMEOUT_CYCLES = 100000;    // About 35 frames of 2048 cycles plus margin.

    logic        audio_clk;
    logic        rst_in;
    logic        mic_data = 1'b0;
    logic        i2s_clk;
    logic        lrcl_clk;
    axil_addr_t  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    axil_addr_t  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    integer      seed = 32'hbb9baa0d;
    int          cycle_count = 0;
    int          mismatch_count = 0;
    int          failure_count = 0;

    // Reference model: queued pairs as sign-extended words, drops counted for overflow.
    logic [31:0] exp_left[$];
    logic [31:0] exp_right[$];
    logic        model_enable = 1'b0;
    int          drop_count = 0;
    int          drops_cleared = 0;

    // Microphone model state.
    logic        prev_lrcl = 1'b0;
    logic        prev_i2s = 1'b0;
    logic        frame_taken = 1'b0;
    logic [63:0] cur_word = '0;
    logic [63:0] shift_word = '0;
    int          bits_left = 0;

    i2s_mic_capture i2s_mic_capture_i (
        .audio_clk (audio_clk),
        .rst_in    (rst_in),
        .mic_data  (mic_data),
        .i2s_clk   (i2s_clk),
        .lrcl_clk  (lrcl_clk),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    initial begin
        audio_clk = 1'b0;
        forever #20 audio_clk = ~audio_clk;
    end

    always @(posedge audio_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks finished: %0d mismatches, %0d other errors", mismatch_count,
                     failure_count + 1);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ----------------------------------------
    // Microphone and frame reference model
    // ----------------------------------------
    // A new word starts at each lrcl_clk fall; the word that just ended is queued
    // if the enable was set when it began. The left word starts one bit in.
    always @(posedge audio_clk) begin
        if (prev_lrcl && !lrcl_clk) begin
            if (frame_taken) begin
                if (exp_left.size() < FIFO_DEPTH) begin
                    exp_left.push_back({{8{cur_word[62]}}, cur_word[62:39]});
                    exp_right.push_back({{8{cur_word[30]}}, cur_word[30:7]});
                end else begin
                    drop_count = drop_count + 1;    // FIFO full, the pair is lost.
                end
            end
            cur_word    = {$random(seed), $random(seed)};
            shift_word  = cur_word;
            bits_left   = 64;
            frame_taken = model_enable;
        end else if (!prev_i2s && i2s_clk && bits_left > 0) begin
            mic_data   <= shift_word[63];    // MSB first on each i2s_clk rise.
            shift_word = shift_word << 1;
            bits_left  = bits_left - 1;
        end
        prev_lrcl = lrcl_clk;
        prev_i2s  = i2s_clk;
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected);
            mismatch_count++;
        end
    endtask

    task automatic write_reg(input axil_addr_t addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int delay;
        delay = $unsigned($random(seed)) % 4;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(posedge audio_clk);
        while (!awready) @(posedge audio_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        if (addr == ADDR_CTRL && strb[0]) begin
            model_enable <= data[0];
            if (data[1]) begin
                drops_cleared = drop_count;
            end
        end
        @(posedge audio_clk);
        while (!bvalid) @(posedge audio_clk);
        resp = bresp;
        repeat (delay) @(posedge audio_clk);
        bready <= 1'b1;
        @(posedge audio_clk);
        bready <= 1'b0;
    endtask

    // A negative hold picks a random rready delay.
    task automatic read_reg(input axil_addr_t addr, input int hold, output logic [31:0] data);
        int          delay;
        logic [31:0] first;
        delay = (hold >= 0) ? hold : $unsigned($random(seed)) % 4;
        araddr  <= addr;
        arvalid <= 1'b1;
        @(posedge audio_clk);
        while (!arready) @(posedge audio_clk);
        arvalid <= 1'b0;
        @(posedge audio_clk);
        while (!rvalid) @(posedge audio_clk);
        first = rdata;
        compare_word("rresp", {30'b0, rresp}, {30'b0, RESP_OKAY});
        repeat (delay) begin
            @(posedge audio_clk);
            compare_word("rdata while stalled", rdata, first);
        end
        rready <= 1'b1;
        @(posedge audio_clk);
        rready <= 1'b0;
        data = first;
    endtask

    task automatic read_pair(input int right_hold);
        logic [31:0] left_got;
        logic [31:0] right_got;
        read_reg(ADDR_LEFT, -1, left_got);
        read_reg(ADDR_RIGHT, right_hold, right_got);
        if (exp_left.size() == 0) begin
            $display("A sample pair was read while the model expected none");
            failure_count++;
        end else begin
            compare_word("LEFT rdata", left_got, exp_left[0]);
            compare_word("RIGHT rdata", right_got, exp_right[0]);
            void'(exp_left.pop_front());
            void'(exp_right.pop_front());
        end
    endtask

    task automatic check_status();
        logic [31:0] got;
        logic [31:0] expected;
        expected = {24'b0, 4'(exp_left.size()), 2'b00, drop_count != drops_cleared,
                    exp_left.size() != 0};
        read_reg(ADDR_STATUS, -1, got);
        compare_word("STATUS rdata", got, expected);
    endtask

    // Returns 16 cycles after an lrcl_clk fall, clear of any FIFO push for a frame.
    task automatic wait_quiet_window();
        @(posedge audio_clk);
        while (!lrcl_clk) @(posedge audio_clk);
        while (lrcl_clk) @(posedge audio_clk);
        repeat (16) @(posedge audio_clk);
    endtask

    task automatic check_clock_outputs();
        int   run;
        int   high_count;
        logic last_i2s;
        run        = 0;
        high_count = 0;
        last_i2s   = 1'b0;
        for (int i = 0; i < 2048; i++) begin
            @(posedge audio_clk);
            if (i == 0 && (i2s_clk || lrcl_clk)) begin
                $display("i2s_clk or lrcl_clk is not low right after reset");
                failure_count++;
            end
            if (lrcl_clk) begin
                high_count++;
            end
            if (i > 0 && i2s_clk != last_i2s) begin
                compare_word("i2s_clk half period", run, 32'd16);
                run = 0;
            end
            run++;
            last_i2s = i2s_clk;
        end
        compare_word("lrcl_clk high cycles", high_count, 32'd1025);
    endtask

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        int          pairs;
        rst_in  = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (4) @(posedge audio_clk);
        rst_in <= 1'b0;

        // ----------------------------------------
        // Reset state, clocks, capture disabled
        // ----------------------------------------
        check_clock_outputs();
        read_reg(ADDR_CTRL, -1, data);
        compare_word("CTRL rdata", data, 32'h0);
        read_reg(ADDR_STATUS, -1, data);
        compare_word("STATUS rdata", data, 32'h0);
        read_reg(ADDR_LEFT, -1, data);
        compare_word("LEFT rdata", data, 32'h0);
        repeat (3) begin
            repeat (2048) @(posedge audio_clk);
            read_reg(ADDR_STATUS, -1, data);
            compare_word("STATUS rdata", data, 32'h0);
        end

        // ----------------------------------------
        // Continuous reading, then overflow
        // ----------------------------------------
        write_reg(ADDR_CTRL, 32'h1, 4'hf, resp);
        pairs = 0;
        while (pairs < 12) begin
            read_reg(ADDR_STATUS, -1, data);
            if (data[0]) begin
                read_pair(-1);
                pairs++;
            end
        end
        repeat (11 * 2048) @(posedge audio_clk);
        check_status();
        wait_quiet_window();
        repeat (8) read_pair(-1);
        check_status();
        write_reg(ADDR_CTRL, 32'h3, 4'hf, resp);
        read_reg(ADDR_CTRL, -1, data);
        compare_word("CTRL rdata", data, 32'h1);
        check_status();

        // ----------------------------------------
        // Write responses and stalled RIGHT read
        // ----------------------------------------
        data = '0;
        while (!data[0]) read_reg(ADDR_STATUS, -1, data);
        wait_quiet_window();
        check_status();
        write_reg(ADDR_STATUS, 32'h0, 4'hf, resp);
        compare_word("bresp", {30'b0, resp}, {30'b0, RESP_OKAY});
        write_reg(ADDR_LEFT, 32'h0, 4'hf, resp);
        compare_word("bresp", {30'b0, resp}, {30'b0, RESP_OKAY});
        write_reg(ADDR_RIGHT, 32'h0, 4'hf, resp);
        compare_word("bresp", {30'b0, resp}, {30'b0, RESP_OKAY});
        check_status();
        write_reg(ADDR_CTRL, 32'h0, 4'h0, resp);
        compare_word("bresp", {30'b0, resp}, {30'b0, RESP_SLVERR});
        read_reg(ADDR_CTRL, -1, data);
        compare_word("CTRL rdata", data, 32'h1);
        pairs = exp_left.size();
        read_pair(6);
        read_reg(ADDR_STATUS, -1, data);
        compare_word("STATUS fill", {28'b0, data[7:4]}, {28'b0, 4'(pairs - 1)});
        check_status();

        $display("Checks finished: %0d mismatches, %0d other errors", mismatch_count,
                 failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: i2s_mic_capture.f
rtl/i2s_pkg.sv
rtl/i2s_clock_gen.sv
rtl/i2s_deserializer.sv
rtl/channel_splitter.sv
rtl/sample_fifo.sv
rtl/axil_sample_regs.sv
rtl/i2s_mic_capture.sv
tests/i2s_mic_capture_props.sv
tests/tb_i2s_mic_capture.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in its output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_i2s_mic_capture \
    -f i2s_mic_capture.f || { echo "BUILD FAILED"; exit 1; }

sim_out="$(./obj_dir/Vtb_i2s_mic_capture)"
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "NO ERRORS" && echo "SIMULATION PASSED" || \
    { echo "SIMULATION FAILED"; exit 1; }
